/* fpu_cvt.f */
verilog/fpu_cvt_pkg.sv
verilog/fpu_clz.sv
verilog/fpu_i2f.sv
verilog/fpu_f2i.sv
verilog/fpu_cvt.sv
+incdir+tb
tb/fpu_cvt_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fpu_cvt testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module fpu_cvt_tb \
  -f fpu_cvt.f \
  -Mdir obj_dir -o fpu_cvt_sim

./obj_dir/fpu_cvt_sim > sim.log 2>&1
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
  exit 0
else
  exit 1
fi

/* tb/fpu_cvt_model.svh */
`ifndef FPU_CVT_MODEL_SVH
`define FPU_CVT_MODEL_SVH

// reference models, results packed as {invalid, inexact, word}

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// integer to single, round to nearest even
function automatic logic [33:0] i2f_model(input logic [31:0] a, input logic sgn);
  logic neg;
  logic [31:0] mag;
  int p;
  int d;
  logic [63:0] kept;
  logic [63:0] rem;
  logic [63:0] half;
  logic rnd;
  logic inexact;
  logic [31:0] z;
  neg = sgn && a[31];
  mag = neg ? (~a + 32'd1) : a;
  if (mag == '0) begin
    return 34'd0;
  end
  // position of the leading one
  p = 31;
  while (!mag[p]) begin
    p--;
  end
  z = {neg, 8'(127 + p), 23'd0};
  inexact = 1'b0;
  if (p <= 23) begin
    // fits, hidden bit falls off the top
    z[22:0] = 23'(mag << (23 - p));
  end else begin
    d = p - 23;
    kept = 64'(mag) >> d;
    rem = 64'(mag) - (kept << d);
    half = 64'd1 << (d - 1);
    inexact = (rem != '0);
    // ties pick the even mantissa
    rnd = (rem > half) || ((rem == half) && kept[0]);
    // a mantissa carry bumps the exponent
    z[30:0] = {8'(127 + p), kept[22:0]} + 31'(rnd);
  end
  return {1'b0, inexact, z};
endfunction

// single to integer, truncate toward zero
function automatic logic [33:0] f2i_model(input logic [31:0] a, input logic sgn);
  logic neg;
  logic [7:0] ex;
  int e;
  logic [63:0] sig;
  logic [63:0] mag;
  logic [63:0] lim;
  logic lost;
  neg = a[31];
  ex = a[30:23];
  e = int'(ex) - 127;
  sig = {40'd0, 1'b1, a[22:0]};
  lost = 1'b0;
  // nan goes to the positive end
  if (ex == 8'hff && a[22:0] != '0) begin
    return {2'b10, sgn ? 32'h7fff_ffff : 32'hffff_ffff};
  end
  // below one, zero and denormals too
  if (e < 0) begin
    return {1'b0, a[30:0] != '0, 32'd0};
  end
  // negative into unsigned, -inf included
  if (!sgn && neg) begin
    return {2'b10, 32'd0};
  end
  // largest legal magnitude, also the saturation word
  lim = sgn ? (neg ? 64'h8000_0000 : 64'h7fff_ffff) : 64'hffff_ffff;
  if (ex == 8'hff || e >= 32) begin
    mag = lim + 64'd1;
  end else if (e >= 23) begin
    mag = sig << (e - 23);
  end else begin
    mag = sig >> (23 - e);
    lost = (sig & ((64'd1 << (23 - e)) - 64'd1)) != '0;
  end
  if (mag > lim) begin
    return {2'b10, lim[31:0]};
  end
  return {1'b0, lost, neg ? -mag[31:0] : mag[31:0]};
endfunction

`endif

/* tb/fpu_cvt_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module fpu_cvt_tb
  import fpu_cvt_pkg::*;
();

  localparam int e_lp = 8;
  localparam int m_lp = 23;
  localparam int w_lp = e_lp + m_lp + 1;
  localparam logic [31:0] seed_lp = 32'hd45bdbde;
  localparam int n_txn_lp = 600;
  localparam int n_dir_lp = 22;
  // 20 cycles per transaction, then reset
  localparam int timeout_lp = n_txn_lp * 20 + 8;

  `include "fpu_cvt_model.svh"

  logic clk_i = 1'b0;
  logic reset_i;
  logic en_i;
  logic v_i;
  cvt_op_e op_i;
  logic signed_i;
  logic [w_lp-1:0] a_i;
  logic ready_o;
  logic v_o;
  logic [w_lp-1:0] z_o;
  cvt_flags_t flags_o;
  logic yumi_i;

  logic [31:0] lfsr_q;
  int en_left = 0;
  int errors = 0;
  int n_accepted = 0;
  int n_results = 0;
  int cycles = 0;

  // expected {flags, word} per accepted request, in order
  logic [33:0] exp_q[$];
  // snapshot of the last result that left
  logic chk_v;
  logic extra_q;
  logic [w_lp-1:0] chk_z;
  logic [w_lp-1:0] exp_z;
  cvt_flags_t chk_f;
  cvt_flags_t exp_f;
  // snapshot of a result held back by the sink
  logic hold_q;
  logic [w_lp-1:0] hold_z;
  cvt_flags_t hold_f;

  fpu_cvt #(
    .e_p(e_lp),
    .m_p(m_lp)
  ) fpu_cvt_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .en_i    (en_i),
    .v_i     (v_i),
    .op_i    (op_i),
    .signed_i(signed_i),
    .a_i     (a_i),
    .ready_o (ready_o),
    .v_o     (v_o),
    .z_o     (z_o),
    .flags_o (flags_o),
    .yumi_i  (yumi_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // corner requests as {op, signed, operand}, op 0 is i2f
  function automatic logic [33:0] directed_req(input int idx);
    case (idx)
      0: return {1'b0, 1'b1, 32'h0000_0000};
      1: return {1'b0, 1'b1, 32'hffff_ffff};
      2: return {1'b0, 1'b1, 32'h8000_0000};
      3: return {1'b0, 1'b0, 32'h00ff_ffff};
      4: return {1'b0, 1'b1, 32'hff00_0001};
      // tie stays even
      5: return {1'b0, 1'b0, 32'h0100_0001};
      // tie rounds up to even
      6: return {1'b0, 1'b0, 32'h0100_0003};
      // carry into the exponent
      7: return {1'b0, 1'b0, 32'hffff_ffff};
      8: return {1'b1, 1'b1, 32'h7fc0_0000};
      9: return {1'b1, 1'b0, 32'h7fc0_0000};
      10: return {1'b1, 1'b1, 32'h7f80_0000};
      11: return {1'b1, 1'b1, 32'hff80_0000};
      12: return {1'b1, 1'b0, 32'hff80_0000};
      13: return {1'b1, 1'b1, 32'h4f00_0000};
      14: return {1'b1, 1'b0, 32'h4f80_0000};
      15: return {1'b1, 1'b1, 32'hcf00_0000};
      16: return {1'b1, 1'b0, 32'hbf80_0000};
      17: return {1'b1, 1'b0, 32'hbf00_0000};
      18: return {1'b1, 1'b1, 32'h0000_0001};
      19: return {1'b1, 1'b1, 32'hc020_0000};
      20: return {1'b1, 1'b0, 32'h4f00_0000};
      21: return {1'b1, 1'b1, 32'h8000_0000};
      default: return '0;
    endcase
  endfunction

  task automatic next_request(input int idx);
    logic [33:0] d;
    logic [31:0] r;
    logic [31:0] b;
    if (idx < n_dir_lp) begin
      d = directed_req(idx);
      op_i = cvt_op_e'(d[33]);
      signed_i = d[32];
      a_i = d[31:0];
    end else begin
      take_bits(1, b);
      op_i = cvt_op_e'(b[0]);
      take_bits(1, b);
      signed_i = b[0];
      take_bits(32, r);
      take_bits(1, b);
      if (b[0]) begin
        take_bits(6, b);
        if (op_i == op_f2i) begin
          // exponent around the integer range
          r[30:23] = 8'd104 + 8'(b[5:0]);
        end else begin
          // short magnitudes, mostly exact
          r = r >> (8 + b[3:0]);
        end
      end
      a_i = r;
    end
    v_i = 1'b1;
  endtask

  task automatic drive_controls();
    logic [31:0] r;
    if (en_left > 0) begin
      en_left--;
      en_i = 1'b0;
    end else begin
      take_bits(4, r);
      // short freeze now and then
      if (r[3:0] == 4'd0) begin
        take_bits(2, r);
        en_left = int'(r[1:0]);
        en_i = 1'b0;
      end else begin
        en_i = 1'b1;
      end
    end
    take_bits(3, r);
    // held back 3 times in 8, never while frozen
    yumi_i = v_o && en_i && (r[2:0] > 3'd2);
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors %0d, accepted %0d, results %0d", errors, n_accepted, n_results);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin : stimulus
    int sent;
    logic taken;
    sent = 0;
    reset_i = 1'b1;
    en_i = 1'b1;
    v_i = 1'b0;
    op_i = op_i2f;
    signed_i = 1'b0;
    a_i = '0;
    yumi_i = 1'b0;
    lfsr_q = seed_lp;
    repeat (8) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    while (sent < n_txn_lp || n_results < n_accepted) begin
      @(posedge clk_i);
      // request taken on this edge
      taken = v_i && ready_o;
      if (taken) begin
        sent++;
      end
      #2;
      drive_controls();
      if (taken || !v_i) begin
        if (sent < n_txn_lp) begin
          next_request(sent);
        end else begin
          v_i = 1'b0;
        end
      end
    end
    repeat (2) @(posedge clk_i);
    count_match_a: assert (n_accepted == n_txn_lp && n_results == n_accepted) else begin
      errors++;
      $display("ERROR t=%0t results expected %0d observed %0d", $time, n_accepted, n_results);
    end
    finish_run(1'b0);
  end

  // scoreboard, pop before push so a result never meets its own request
  always @(posedge clk_i) begin : scoreboard
    logic [33:0] head;
    if (reset_i) begin
      chk_v <= 1'b0;
      extra_q <= 1'b0;
      hold_q <= 1'b0;
    end else begin
      chk_v <= 1'b0;
      extra_q <= 1'b0;
      if (v_o && yumi_i) begin
        n_results++;
        if (exp_q.size() == 0) begin
          extra_q <= 1'b1;
        end else begin
          head = exp_q.pop_front();
          chk_v <= 1'b1;
          chk_z <= z_o;
          chk_f <= flags_o;
          exp_z <= head[31:0];
          exp_f <= head[33:32];
        end
      end
      if (v_i && ready_o) begin
        n_accepted++;
        if (op_i == op_i2f) begin
          exp_q.push_back(i2f_model(a_i, signed_i));
        end else begin
          exp_q.push_back(f2i_model(a_i, signed_i));
        end
      end
      hold_q <= v_o && !yumi_i;
      hold_z <= z_o;
      hold_f <= flags_o;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > timeout_lp) begin
      $display("timeout after %0d cycles, %0d of %0d results", cycles, n_results, n_accepted);
      finish_run(1'b1);
    end
  end

  // checks run on the falling edge, all signals settled
  z_match_a: assert property (
    @(negedge clk_i) disable iff (reset_i) chk_v |-> (chk_z == exp_z)
  ) else begin
    errors++;
    $display("ERROR t=%0t z_o expected %h observed %h", $time, exp_z, chk_z);
  end

  flags_match_a: assert property (
    @(negedge clk_i) disable iff (reset_i) chk_v |-> (chk_f == exp_f)
  ) else begin
    errors++;
    $display("ERROR t=%0t flags_o expected %b observed %b", $time, exp_f, chk_f);
  end

  no_extra_result_a: assert property (
    @(negedge clk_i) disable iff (reset_i) !extra_q
  ) else begin
    errors++;
    $display("t=%0t a result left with no request waiting for it", $time);
  end

  // held result stays put
  held_stable_a: assert property (
    @(negedge clk_i) disable iff (reset_i)
      hold_q |-> (v_o && z_o == hold_z && flags_o == hold_f)
  ) else begin
    errors++;
    $display("ERROR t=%0t z_o expected %h observed %h, flags_o expected %b observed %b",
             $time, hold_z, z_o, hold_f, flags_o);
  end

  frozen_not_ready_a: assert property (
    @(negedge clk_i) disable iff (reset_i) !en_i |-> !ready_o
  ) else begin
    errors++;
    $display("t=%0t ready_o was high while en_i was low", $time);
  end

  reset_idle_a: assert property (
    @(negedge clk_i) reset_i |-> !v_o
  ) else begin
    errors++;
    $display("t=%0t v_o was high during reset", $time);
  end

endmodule

`default_nettype wire

/* verilog/fpu_clz.sv */
`default_nettype none
`timescale 1ns/1ps

module fpu_clz
  import fpu_cvt_pkg::*;
#(
  parameter int width_p = 32
) (
  input  wire [width_p-1:0] i,
  output shamt_t            num_zero_o
);

  // search runs on a power-of-two window
  localparam int levels_lp = $clog2(width_p);
  localparam int pow2_lp = 1 << levels_lp;

  logic [width_p+pow2_lp-1:0] ext;
  logic [pow2_lp-1:0] padded;
  logic [pow2_lp-1:0] win;
  shamt_t cnt;

  // pad below the lsb with ones, so all-zero input stops at width_p
  assign ext = {i, {pow2_lp{1'b1}}};
  assign padded = ext[width_p+pow2_lp-1 -: pow2_lp];

  always_comb begin
    win = padded;
    cnt = '0;
    // halve the window each step, window kept at the top of win
    for (int lvl = levels_lp - 1; lvl >= 0; lvl--) begin
      // upper half empty, so count it and move to the lower half
      if ((win >> (pow2_lp - (1 << lvl))) == '0) begin
        cnt = cnt + shamt_t'(1 << lvl);
        win = win << (1 << lvl);
      end
    end
    // last single bit
    if (!win[pow2_lp-1]) begin
      cnt = cnt + 1'b1;
    end
  end

  assign num_zero_o = cnt;

endmodule

`default_nettype wire

/* verilog/fpu_cvt.sv */
`default_nettype none
`timescale 1ns/1ps

module fpu_cvt
  import fpu_cvt_pkg::*;
#(
  parameter int e_p = 8,
  parameter int m_p = 23,
  localparam int width_lp = e_p + m_p + 1
) (
  input  wire                 clk_i,
  input  wire                 reset_i,
  input  wire                 en_i,

  input  wire                 v_i,
  input  wire cvt_op_e        op_i,
  input  wire                 signed_i,
  input  wire  [width_lp-1:0] a_i,
  output logic                ready_o,

  output logic                v_o,
  output logic [width_lp-1:0] z_o,
  output cvt_flags_t          flags_o,
  input  wire                 yumi_i
);

  logic i2f_sel, i2f_free, f2i_free;
  logic i2f_v_li, i2f_ready_lo, i2f_v_lo, i2f_yumi_li;
  logic f2i_v_li, f2i_ready_lo, f2i_v_lo, f2i_yumi_li;
  logic [width_lp-1:0] i2f_z_lo, f2i_z_lo;
  cvt_flags_t i2f_flags_lo, f2i_flags_lo;

  assign i2f_sel = (op_i == op_i2f);

  // one op kind in flight, unless the other result leaves this edge
  assign i2f_free = ~f2i_v_lo | yumi_i;
  assign f2i_free = ~i2f_v_lo | yumi_i;

  // steer request by op
  assign i2f_v_li = v_i & i2f_sel & i2f_free;
  assign f2i_v_li = v_i & ~i2f_sel & f2i_free;
  assign ready_o = i2f_sel ? (i2f_ready_lo & i2f_free) : (f2i_ready_lo & f2i_free);

  fpu_i2f #(
    .e_p(e_p),
    .m_p(m_p)
  ) i2f_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .en_i    (en_i),
    .v_i     (i2f_v_li),
    .signed_i(signed_i),
    .a_i     (a_i),
    .ready_o (i2f_ready_lo),
    .v_o     (i2f_v_lo),
    .z_o     (i2f_z_lo),
    .flags_o (i2f_flags_lo),
    .yumi_i  (i2f_yumi_li)
  );

  fpu_f2i #(
    .e_p(e_p),
    .m_p(m_p)
  ) f2i_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .en_i    (en_i),
    .v_i     (f2i_v_li),
    .signed_i(signed_i),
    .a_i     (a_i),
    .ready_o (f2i_ready_lo),
    .v_o     (f2i_v_lo),
    .z_o     (f2i_z_lo),
    .flags_o (f2i_flags_lo),
    .yumi_i  (f2i_yumi_li)
  );

  // merge result side, at most one holder
  assign v_o = i2f_v_lo | f2i_v_lo;
  assign z_o = f2i_v_lo ? f2i_z_lo : i2f_z_lo;
  assign flags_o = f2i_v_lo ? f2i_flags_lo : i2f_flags_lo;
  assign i2f_yumi_li = yumi_i & i2f_v_lo;
  assign f2i_yumi_li = yumi_i & f2i_v_lo;

  // ordering gate keeps the two stages exclusive
  valid_exclusive_a: assert property (
    @(posedge clk_i) disable iff (reset_i) !(i2f_v_lo && f2i_v_lo)
  );

endmodule

`default_nettype wire

/* verilog/fpu_cvt_pkg.sv */
`default_nettype none

package fpu_cvt_pkg;

  // requested conversion direction
  typedef enum logic {
    op_i2f = 1'b0,
    op_f2i = 1'b1
  } cvt_op_e;

  // exception flags returned with every result
  typedef struct packed {
    // nan or inf input, or f2i out of range
    logic invalid;
    // result differs from the exact value
    logic inexact;
  } cvt_flags_t;

  // shift counts, enough for words up to 64 bits
  typedef logic [5:0] shamt_t;

endpackage

`default_nettype wire

/* verilog/fpu_f2i.sv */
`default_nettype none
`timescale 1ns/1ps

module fpu_f2i
  import fpu_cvt_pkg::*;
#(
  parameter int e_p = 8,
  parameter int m_p = 23,
  localparam int width_lp = e_p + m_p + 1
) (
  input  wire                 clk_i,
  input  wire                 reset_i,
  input  wire                 en_i,

  input  wire                 v_i,
  input  wire                 signed_i,
  input  wire  [width_lp-1:0] a_i,
  output logic                ready_o,

  output logic                v_o,
  output logic [width_lp-1:0] z_o,
  output cvt_flags_t          flags_o,
  input  wire                 yumi_i
);

  localparam int bias_lp = (1 << (e_p - 1)) - 1;
  // exponent where the integer part fills the whole word
  localparam int exp_top_lp = bias_lp + width_lp - 1;
  localparam logic [width_lp-1:0] smax_lp = {1'b0, {(width_lp-1){1'b1}}};
  localparam logic [width_lp-1:0] smin_lp = {1'b1, {(width_lp-1){1'b0}}};

  logic v_r;
  logic accept;

  assign v_o = v_r;
  assign ready_o = en_i & (~v_r | yumi_i);
  assign accept = v_i & ready_o;

  // front half unpacks the word
  logic sign;
  logic [e_p-1:0] exp;
  logic [m_p-1:0] man;
  logic exp_max;
  logic nan;
  logic inf;
  logic below_one;
  logic nz;
  logic ovf;
  logic in_range;
  logic neg_uns;
  logic sat;
  shamt_t shamt;

  assign sign = a_i[width_lp-1];
  assign exp = a_i[width_lp-2 -: e_p];
  assign man = a_i[m_p-1:0];

  // classify
  assign exp_max = &exp;
  assign nan = exp_max & (|man);
  assign inf = exp_max & ~(|man);
  // magnitude below one covers zero and denormals
  assign below_one = int'(exp) < bias_lp;
  assign nz = |a_i[width_lp-2:0];

  always_comb begin
    if (signed_i) begin
      // only -2^(w-1) is legal at the top exponent
      ovf = (int'(exp) > exp_top_lp) ||
            ((int'(exp) == exp_top_lp) && !(sign && (man == '0)));
    end else begin
      ovf = int'(exp) > exp_top_lp;
    end
  end

  // negative to unsigned with magnitude at least one
  assign neg_uns = ~signed_i & sign & ~nan & ~below_one;
  assign sat = nan | (~neg_uns & (inf | ovf));

  // right shift that drops the fraction bits
  assign in_range = ~below_one & (int'(exp) <= exp_top_lp);
  assign shamt = in_range ? shamt_t'(exp_top_lp - int'(exp)) : '0;

  // stage register
  logic sat_r;
  logic nan_r;
  logic below_one_r;
  logic neg_uns_r;
  logic nz_r;
  logic neg_r;
  logic signed_r;
  logic [m_p-1:0] man_r;
  shamt_t shamt_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (accept) begin
      v_r <= 1'b1;
    end else if (yumi_i) begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      sat_r <= sat;
      nan_r <= nan;
      below_one_r <= below_one;
      neg_uns_r <= neg_uns;
      nz_r <= nz;
      neg_r <= signed_i & sign;
      signed_r <= signed_i;
      man_r <= man;
      shamt_r <= shamt;
    end
  end

  // back half
  logic [width_lp-1:0] aligned;
  logic [width_lp-1:0] shifted;
  logic [width_lp-1:0] trunc;
  logic lost;

  // hidden one on the msb with the fraction below
  assign aligned = {1'b1, man_r, {e_p{1'b0}}};
  assign shifted = aligned >> shamt_r;
  // any bit shifted out makes it inexact
  assign lost = |(aligned & ~({width_lp{1'b1}} << shamt_r));
  assign trunc = neg_r ? -shifted : shifted;

  always_comb begin
    if (sat_r) begin
      if (!signed_r) begin
        z_o = '1;
      end else if (neg_r && !nan_r) begin
        z_o = smin_lp;
      end else begin
        // nan goes to max positive
        z_o = smax_lp;
      end
    end else if (below_one_r || neg_uns_r) begin
      z_o = '0;
    end else begin
      z_o = trunc;
    end
  end

  assign flags_o.invalid = sat_r | neg_uns_r;
  assign flags_o.inexact = below_one_r ? nz_r : (~sat_r & ~neg_uns_r & lost);

  // sink only acks a held result
  yumi_needs_valid_a: assert property (
    @(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o
  );

endmodule

`default_nettype wire

/* verilog/fpu_i2f.sv */
`default_nettype none
`timescale 1ns/1ps

module fpu_i2f
  import fpu_cvt_pkg::*;
#(
  parameter int e_p = 8,
  parameter int m_p = 23,
  localparam int width_lp = e_p + m_p + 1
) (
  input  wire                 clk_i,
  input  wire                 reset_i,
  input  wire                 en_i,

  input  wire                 v_i,
  input  wire                 signed_i,
  input  wire  [width_lp-1:0] a_i,
  output logic                ready_o,

  output logic                v_o,
  output logic [width_lp-1:0] z_o,
  output cvt_flags_t          flags_o,
  input  wire                 yumi_i
);

  localparam int bias_lp = (1 << (e_p - 1)) - 1;
  // biased exponent when the msb of the word is set
  localparam int exp_top_lp = bias_lp + width_lp - 1;

  logic v_r;
  logic accept;

  // single slot, refilled on the edge it drains
  assign v_o = v_r;
  assign ready_o = en_i & (~v_r | yumi_i);
  assign accept = v_i & ready_o;

  // front half
  logic sign;
  logic [width_lp-1:0] mag;
  shamt_t shamt;
  logic zero;

  // negative only when signed and msb set
  assign sign = signed_i & a_i[width_lp-1];
  // min signed value negates to itself, still the right magnitude
  assign mag = sign ? -a_i : a_i;
  assign zero = ~|mag;

  fpu_clz #(
    .width_p(width_lp)
  ) clz_inst (
    .i         (mag),
    .num_zero_o(shamt)
  );

  // stage register
  logic [width_lp-1:0] mag_r;
  shamt_t shamt_r;
  logic sign_r;
  logic zero_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (accept) begin
      v_r <= 1'b1;
    end else if (yumi_i) begin
      v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mag_r <= mag;
      shamt_r <= shamt;
      sign_r <= sign;
      zero_r <= zero;
    end
  end

  // back half
  logic [width_lp-1:0] norm;
  logic [m_p-1:0] mant;
  logic round_bit;
  logic sticky;
  logic round_up;
  logic [e_p-1:0] exp;
  logic [width_lp-2:0] rounded;

  // leading one lands on the msb, then drops as hidden bit
  assign norm = mag_r << shamt_r;
  assign mant = norm[width_lp-2 -: m_p];
  // first bit below the mantissa, rest is sticky
  assign round_bit = norm[e_p-1];
  assign sticky = |norm[e_p-2:0];

  assign exp = e_p'(exp_top_lp - int'(shamt_r));

  // nearest even, ties go to even mantissa
  assign round_up = round_bit & (mant[0] | sticky);
  // mantissa carry ripples into the exponent
  assign rounded = {exp, mant} + (width_lp-1)'(round_up);

  assign z_o = zero_r ? '0 : {sign_r, rounded};
  assign flags_o = '{invalid: 1'b0, inexact: round_bit | sticky};

  // sink only acks a held result
  yumi_needs_valid_a: assert property (
    @(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o
  );

  // nonzero value always has its leading one inside the word
  shamt_in_word_a: assert property (
    @(posedge clk_i) disable iff (reset_i) (v_r && !zero_r) |-> (int'(shamt_r) < width_lp)
  );

endmodule

`default_nettype wire
